// File: arcade_io_top.f
+incdir+source
source/ps2_pkg.sv
source/ctrl_pkg.sv
source/ps2_frame_decoder.sv
source/key_state_tracker.sv
source/control_mixer.sv
source/audio_sigma_delta.sv
source/arcade_io_top.sv
tests/io_checker.sv
tests/tb_arcade_io.sv

// File: source/arcade_io_top.sv
/*
 * arcade input and audio front end
 * PS/2 keyboard and joysticks in, core player inputs and 1-bit audio out
 */
`timescale 1ns/1ps
`default_nettype none

`include "io_consts.svh"

module arcade_io_top (
	input  logic                     clk_sys_i,
	input  logic                     arst_n_i,
	input  logic                     ps2_clk_i,
	input  logic                     ps2_data_i,
	input  ctrl_pkg::pad_t           joy0_i,
	input  ctrl_pkg::pad_t           joy1_i,
	input  logic                     upright_i,
	input  logic                     test_i,
	input  logic                     cocktail_i,
	input  ctrl_pkg::audio_level_t   audio_level_i,
	output ctrl_pkg::player_inputs_t player_o,
	output ctrl_pkg::dir_t [1:0]     joystick_o,
	output logic                     frame_err_o,
	output logic                     audio_o
);
	import ps2_pkg::*;

	scan_code_t               code;
	logic                     code_valid;
	held_keys_t               held;
	logic [`IO_DAC_WIDTH-1:0] dac_level;

	// ==================
	// keyboard path, a raw stop bit edge reaches player_o six cycles later
	ps2_frame_decoder u_decoder (
		.clk_sys_i    (clk_sys_i),
		.arst_n_i     (arst_n_i),
		.ps2_clk_i    (ps2_clk_i),
		.ps2_data_i   (ps2_data_i),
		.code_o       (code),
		.code_valid_o (code_valid),
		.frame_err_o  (frame_err_o)
	);

	key_state_tracker u_tracker (
		.clk_sys_i    (clk_sys_i),
		.arst_n_i     (arst_n_i),
		.code_i       (code),
		.code_valid_i (code_valid),
		.held_o       (held)
	);

	control_mixer u_mixer (
		.clk_sys_i  (clk_sys_i),
		.arst_n_i   (arst_n_i),
		.held_i     (held),
		.joy0_i     (joy0_i),
		.joy1_i     (joy1_i),
		.upright_i  (upright_i),
		.test_i     (test_i),
		.cocktail_i (cocktail_i),
		.player_o   (player_o),
		.joystick_o (joystick_o)
	);

	// ==================
	// repeating the 4-bit level scales 0..15 onto 0..255 in steps of 17
	assign dac_level = {2{audio_level_i}};

	audio_sigma_delta u_dac (
		.clk_sys_i (clk_sys_i),
		.arst_n_i  (arst_n_i),
		.level_i   (dac_level),
		.audio_o   (audio_o)
	);

endmodule

`default_nettype wire

// File: source/audio_sigma_delta.sv
/*
 * first order sigma-delta DAC
 * the accumulator carry forms a 1-bit stream whose density tracks the level
 */
`timescale 1ns/1ps
`default_nettype none

`include "io_consts.svh"

module audio_sigma_delta (
	input  logic                     clk_sys_i,
	input  logic                     arst_n_i,
	input  logic [`IO_DAC_WIDTH-1:0] level_i,
	output logic                     audio_o
);

	// top bit holds the last carry, the rest is the running remainder
	logic [`IO_DAC_WIDTH:0] acc_q;
	logic [`IO_DAC_WIDTH:0] acc_sum;

	// ==================
	// the remainder wraps every 2**width steps of the full scale level,
	// so a constant level gives exactly level ones per 256 cycles
	assign acc_sum = {1'b0, acc_q[`IO_DAC_WIDTH-1:0]} + {1'b0, level_i};

	always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			acc_q <= '0;
		end else begin
			acc_q <= acc_sum;
		end
	end

	// the carry is already a register bit, so the output needs no extra stage
	assign audio_o = acc_q[`IO_DAC_WIDTH];

endmodule

`default_nettype wire

// File: source/control_mixer.sv
/*
 * control mixer
 * merges keyboard and joysticks, rotates for upright cabinets, drives active low inputs
 */
`timescale 1ns/1ps
`default_nettype none

module control_mixer (
	input  logic                     clk_sys_i,
	input  logic                     arst_n_i,
	input  ps2_pkg::held_keys_t      held_i,
	input  ctrl_pkg::pad_t           joy0_i,
	input  ctrl_pkg::pad_t           joy1_i,
	input  logic                     upright_i,
	input  logic                     test_i,
	input  logic                     cocktail_i,
	output ctrl_pkg::player_inputs_t player_o,
	output ctrl_pkg::dir_t [1:0]     joystick_o
);
	import ctrl_pkg::*;

	logic           up_any;
	logic           down_any;
	logic           left_any;
	logic           right_any;
	logic           fire1_any;
	logic           fire2_any;
	dir_t           dir_d;
	player_inputs_t player_d;

	// ==================
	// any source pressing a control counts, all of these are active high
	assign up_any    = held_i.up    | joy0_i.up    | joy1_i.up;
	assign down_any  = held_i.down  | joy0_i.down  | joy1_i.down;
	assign left_any  = held_i.left  | joy0_i.left  | joy1_i.left;
	assign right_any = held_i.right | joy0_i.right | joy1_i.right;
	assign fire1_any = held_i.fire1 | joy0_i.fire1 | joy1_i.fire1;
	assign fire2_any = held_i.fire2 | joy0_i.fire2 | joy1_i.fire2;

	// upright cabinets mount the monitor turned, so the stick is turned with it
	always_comb begin
		dir_d.up    = ~(upright_i ? right_any : up_any);
		dir_d.down  = ~(upright_i ? left_any  : down_any);
		dir_d.left  = ~(upright_i ? up_any    : left_any);
		dir_d.right = ~(upright_i ? down_any  : right_any);
	end

	// player word in the core's order, inverted to active low
	always_comb begin
		player_d.coin_r   = ~held_i.coin_r;
		player_d.coin_c   = ~held_i.coin_c;
		player_d.coin_l   = ~held_i.coin_l;
		player_d.test     = ~test_i;
		player_d.cocktail = ~cocktail_i;
		player_d.slam     = ~held_i.slam;
		player_d.start2   = ~held_i.start2;
		player_d.start1   = ~held_i.start1;
		player_d.fire1    = ~fire1_any;
		player_d.fire2    = ~fire2_any;
	end

	// outputs come out of reset inactive, which is all ones
	always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			player_o   <= '1;
			joystick_o <= '1;
		end else begin
			player_o   <= player_d;
			// both player nibbles carry the same directions
			joystick_o <= {dir_d, dir_d};
		end
	end

endmodule

`default_nettype wire

// File: source/ctrl_pkg.sv
/*
 * control side types
 * joystick pads, the game core player inputs and the sound level
 */
`default_nettype none

package ctrl_pkg;

	// ==================
	// digital joystick as delivered by the host, active high
	typedef struct packed {
		logic       up;
		logic       down;
		logic       left;
		logic       right;
		logic       fire1;
		logic       fire2;
		// remaining buttons are not wired to anything in this core
		logic [1:0] spare;
	} pad_t;

	// ==================
	// player input word of the game core, every bit active low
	// bit order matches the core's playerinput port, right coin at the top
	typedef struct packed {
		logic coin_r;
		logic coin_c;
		logic coin_l;
		logic test;
		logic cocktail;
		logic slam;
		logic start2;
		logic start1;
		logic fire1;
		logic fire2;
	} player_inputs_t;

	// one direction nibble of the core joystick port, active low
	// the core takes two of these side by side
	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
	} dir_t;

	// sound level from the game core
	typedef logic [3:0] audio_level_t;

endpackage

`default_nettype wire

// File: source/io_consts.svh
/*
 * arcade input and audio front end constants
 * frame format, synchronizer depth, DAC width and the scan codes in use
 */
`ifndef IO_CONSTS_SVH
`define IO_CONSTS_SVH

// start bit, eight data bits, odd parity and stop bit
`define IO_PS2_FRAME_BITS   11
// system cycles of PS/2 clock high time that abandon a partial frame
`define IO_PS2_IDLE_CYCLES  2048
`define IO_SYNC_STAGES      2
`define IO_DAC_WIDTH        8

// ==================
// prefix bytes sent ahead of extended and release codes
`define IO_SC_EXT           8'hE0
`define IO_SC_BREAK         8'hF0

// arrow keys only count after an E0 prefix
`define IO_SC_UP            8'h75
`define IO_SC_DOWN          8'h72
`define IO_SC_LEFT          8'h6B
`define IO_SC_RIGHT         8'h74

// plain keys for fire, start, coins and slam
`define IO_SC_SPACE         8'h29
`define IO_SC_LALT          8'h11
`define IO_SC_1             8'h16
`define IO_SC_2             8'h1E
`define IO_SC_5             8'h2E
`define IO_SC_6             8'h36
`define IO_SC_7             8'h3D
`define IO_SC_T             8'h2C

`endif

// File: source/key_state_tracker.sv
/*
 * key state tracker
 * follows E0 and F0 prefixes and keeps one held bit per mapped key
 */
`timescale 1ns/1ps
`default_nettype none

`include "io_consts.svh"

module key_state_tracker (
	input  logic                clk_sys_i,
	input  logic                arst_n_i,
	input  ps2_pkg::scan_code_t code_i,
	input  logic                code_valid_i,
	output ps2_pkg::held_keys_t held_o
);
	import ps2_pkg::*;

	// prefix memory, the break state sits on top of the extended state
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_EXT,
		ST_BREAK,
		ST_EXT_BREAK
	} state_t;

	state_t     state_q;
	held_keys_t key_mask;
	logic       is_ext;
	logic       is_make;
	logic       is_prefix;

	assign is_ext    = (state_q == ST_EXT) || (state_q == ST_EXT_BREAK);
	assign is_make   = (state_q == ST_IDLE) || (state_q == ST_EXT);
	assign is_prefix = (code_i == `IO_SC_EXT) || (code_i == `IO_SC_BREAK);

	// ==================
	// decode the final byte into a one hot key mask
	// arrows are only recognised after E0 and the plain keys only without it
	always_comb begin
		key_mask = '0;
		if (is_ext) begin
			case (code_i)
				`IO_SC_UP:    key_mask.up    = 1'b1;
				`IO_SC_DOWN:  key_mask.down  = 1'b1;
				`IO_SC_LEFT:  key_mask.left  = 1'b1;
				`IO_SC_RIGHT: key_mask.right = 1'b1;
				default:      key_mask       = '0;
			endcase
		end else begin
			case (code_i)
				`IO_SC_SPACE: key_mask.fire1  = 1'b1;
				`IO_SC_LALT:  key_mask.fire2  = 1'b1;
				`IO_SC_1:     key_mask.start1 = 1'b1;
				`IO_SC_2:     key_mask.start2 = 1'b1;
				`IO_SC_5:     key_mask.coin_l = 1'b1;
				`IO_SC_6:     key_mask.coin_c = 1'b1;
				`IO_SC_7:     key_mask.coin_r = 1'b1;
				`IO_SC_T:     key_mask.slam   = 1'b1;
				default:      key_mask        = '0;
			endcase
		end
	end

	// ==================
	// prefixes move the FSM along, any other byte ends the sequence
	// unknown codes still return to idle but leave every bit alone
	always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= ST_IDLE;
			held_o  <= '0;
		end else if (code_valid_i) begin
			if (code_i == `IO_SC_EXT) begin
				state_q <= (state_q == ST_BREAK) ? ST_EXT_BREAK : ST_EXT;
			end else if (code_i == `IO_SC_BREAK) begin
				state_q <= is_ext ? ST_EXT_BREAK : ST_BREAK;
			end else begin
				state_q <= ST_IDLE;
			end
			if (!is_prefix) begin
				// make sets the bit and break clears it
				held_o <= is_make ? (held_o | key_mask) : (held_o & ~key_mask);
			end
		end
	end

endmodule

`default_nettype wire

// File: source/ps2_frame_decoder.sv
/*
 * PS/2 frame decoder
 * samples the device clocked line and emits one checked scan code per frame
 */
`timescale 1ns/1ps
`default_nettype none

`include "io_consts.svh"

module ps2_frame_decoder (
	input  logic                clk_sys_i,
	input  logic                arst_n_i,
	input  logic                ps2_clk_i,
	input  logic                ps2_data_i,
	output ps2_pkg::scan_code_t code_o,
	output logic                code_valid_o,
	output logic                frame_err_o
);
	import ps2_pkg::*;

	localparam int BIT_CNT_W  = $clog2(`IO_PS2_FRAME_BITS);
	localparam int IDLE_CNT_W = $clog2(`IO_PS2_IDLE_CYCLES);
	localparam int SHIFT_W    = `IO_PS2_FRAME_BITS - 1;

	logic [`IO_SYNC_STAGES-1:0] clk_sync_q;
	logic [`IO_SYNC_STAGES-1:0] data_sync_q;
	logic                       clk_prev_q;
	logic                       fall_q;
	logic                       data_q;
	logic [BIT_CNT_W-1:0]       bit_cnt_q;
	logic [IDLE_CNT_W-1:0]      idle_cnt_q;
	logic [SHIFT_W-1:0]         shift_q;
	logic                       last_bit;
	logic                       idle_timeout;
	logic                       frame_ok;
	scan_code_t                 frame_data;

	// ==================
	// both lines idle high, so the synchronizers come out of reset at one
	// the edge flag and the sampled data bit are registered together so they line up
	always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			clk_sync_q  <= '1;
			data_sync_q <= '1;
			clk_prev_q  <= 1'b1;
			fall_q      <= 1'b0;
			data_q      <= 1'b1;
		end else begin
			clk_sync_q  <= {clk_sync_q[`IO_SYNC_STAGES-2:0], ps2_clk_i};
			data_sync_q <= {data_sync_q[`IO_SYNC_STAGES-2:0], ps2_data_i};
			clk_prev_q  <= clk_sync_q[`IO_SYNC_STAGES-1];
			fall_q      <= clk_prev_q & ~clk_sync_q[`IO_SYNC_STAGES-1];
			data_q      <= data_sync_q[`IO_SYNC_STAGES-1];
		end
	end

	// ==================
	// idle watchdog counts system cycles with the PS/2 clock high
	// it saturates, and a full count abandons whatever partial frame is in flight
	always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			idle_cnt_q <= '0;
		end else if (!clk_sync_q[`IO_SYNC_STAGES-1]) begin
			idle_cnt_q <= '0;
		end else if (!idle_timeout) begin
			idle_cnt_q <= idle_cnt_q + 1'b1;
		end
	end

	assign idle_timeout = (idle_cnt_q == IDLE_CNT_W'(`IO_PS2_IDLE_CYCLES - 1));

	// the shift register holds start, data and parity once the stop bit arrives
	// bits enter at the top, so the start bit ends up in bit 0
	assign last_bit   = (bit_cnt_q == BIT_CNT_W'(`IO_PS2_FRAME_BITS - 1));
	assign frame_data = shift_q[8:1];
	// start must be 0, data plus parity must hold an odd count of ones, stop must be 1
	assign frame_ok   = ~shift_q[0] & (^shift_q[SHIFT_W-1:1]) & data_q;

	// frame counter and the one cycle result pulses
	always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			bit_cnt_q    <= '0;
			code_valid_o <= 1'b0;
			frame_err_o  <= 1'b0;
		end else begin
			code_valid_o <= 1'b0;
			frame_err_o  <= 1'b0;
			if (fall_q) begin
				if (last_bit) begin
					bit_cnt_q    <= '0;
					code_valid_o <= frame_ok;
					frame_err_o  <= ~frame_ok;
				end else begin
					bit_cnt_q <= bit_cnt_q + 1'b1;
				end
			end else if (idle_timeout) begin
				bit_cnt_q <= '0;
			end
		end
	end

	// payload registers, only meaningful alongside the valid pulse
	always_ff @(posedge clk_sys_i) begin
		if (fall_q) begin
			if (last_bit) begin
				code_o <= frame_data;
			end else begin
				shift_q <= {data_q, shift_q[SHIFT_W-1:1]};
			end
		end
	end

endmodule

`default_nettype wire

// File: source/ps2_pkg.sv
/*
 * keyboard side types
 * scan code bytes and the vector of keys currently held down
 */
`default_nettype none

package ps2_pkg;

	// one byte as it comes off the PS/2 line
	typedef logic [7:0] scan_code_t;

	// ==================
	// one bit per mapped key, 1 while the key is held
	// the tracker has already consumed the E0 and F0 prefixes
	typedef struct packed {
		// arrow cluster, extended codes
		logic up;
		logic down;
		logic left;
		logic right;
		// space and left alt
		logic fire1;
		logic fire2;
		// keys 1 and 2
		logic start1;
		logic start2;
		// keys 5, 6 and 7 map to the three coin slots
		logic coin_l;
		logic coin_c;
		logic coin_r;
		// key T tilts the machine
		logic slam;
	} held_keys_t;

endpackage

`default_nettype wire

// File: tests/io_checker.sv
/*
 * output checker for the arcade front end testbench
 * compares the DUT ports with the reference model and keeps per-test and total counts
 */
`timescale 1ns/1ps
`default_nettype none

module io_checker (
	input  logic                     clk_i,
	input  ctrl_pkg::player_inputs_t player_i,
	input  ctrl_pkg::dir_t [1:0]     joystick_i,
	input  logic                     frame_err_i,
	input  logic                     audio_i,
	input  ctrl_pkg::player_inputs_t exp_player_i,
	input  ctrl_pkg::dir_t [1:0]     exp_joystick_i,
	input  logic [15:0]              exp_ones_i,
	input  logic [7:0]               exp_ferr_i,
	input  logic                     cmp_io_i,
	input  logic                     audio_cnt_i,
	input  logic                     audio_chk_i,
	input  logic [2:0]               test_id_i,
	input  logic                     test_end_i,
	input  logic                     report_i,
	output int                       err_total_o
);
	import ctrl_pkg::*;

	int test_checks = 0;
	int test_errors = 0;
	int all_checks  = 0;
	int all_errors  = 0;
	int tests_done  = 0;
	int ferr_seen   = 0;
	int ones_seen   = 0;

	assign err_total_o = all_errors;

	function automatic string test_name(input logic [2:0] id);
		case (id)
			3'd1:    return "reset state";
			3'd2:    return "random key sequences";
			3'd3:    return "joystick and cabinet settings";
			3'd4:    return "bad parity frames";
			3'd5:    return "audio density";
			default: return "unnamed";
		endcase
	endfunction

	// ====================
	// everything is sampled on the rising edge, half a cycle after the stimulus moved
	// the DUT registers update in the same step, so the values seen here are the settled ones
	always @(posedge clk_i) begin
		if (cmp_io_i) begin
			test_checks++;
			if (player_i !== exp_player_i) begin
				test_errors++;
				$display("error player_o expected 0x%03h got 0x%03h at %0t",
					exp_player_i, player_i, $time);
			end
			if (joystick_i !== exp_joystick_i) begin
				test_errors++;
				$display("error joystick_o expected 0x%02h got 0x%02h at %0t",
					exp_joystick_i, joystick_i, $time);
			end
		end

		// every frame_err pulse is counted and the total is judged at the end of the test
		if (frame_err_i === 1'b1) begin
			ferr_seen++;
		end

		// density window, one sample per cycle while the testbench holds the count enable
		if (audio_cnt_i && (audio_i === 1'b1)) begin
			ones_seen++;
		end
		if (audio_chk_i) begin
			test_checks++;
			if (ones_seen != int'(exp_ones_i)) begin
				test_errors++;
				$display("audio_o gave %0d ones in 256 cycles where %0d were expected",
					ones_seen, exp_ones_i);
			end
			ones_seen = 0;
		end

		// ====================
		// close the running test with its own line
		if (test_end_i) begin
			test_checks++;
			if (ferr_seen != int'(exp_ferr_i)) begin
				test_errors++;
				$display("frame_err_o pulsed %0d times during this test where %0d were expected",
					ferr_seen, exp_ferr_i);
			end
			$display("test %0d %s: %0d checks, %0d errors",
				test_id_i, test_name(test_id_i), test_checks, test_errors);
			all_checks += test_checks;
			all_errors += test_errors;
			tests_done++;
			test_checks = 0;
			test_errors = 0;
			ferr_seen   = 0;
		end

		if (report_i) begin
			$display("totals: %0d tests, %0d checks, %0d errors",
				tests_done, all_checks, all_errors);
		end
	end

endmodule

`default_nettype wire

// File: tests/tb_arcade_io.sv
/*
 * testbench for the arcade input and audio front end
 * random PS/2 traffic, joystick moves and audio levels against a reference model
 */
`timescale 1ns/1ps
`default_nettype none

`include "io_consts.svh"

module tb_arcade_io;
	import ctrl_pkg::*;

	// one PS/2 bit lasts two half periods of system cycles
	localparam int HALF_BIT      = 10;
	localparam int FRAME_CYC     = 2 * HALF_BIT * `IO_PS2_FRAME_BITS;
	localparam int SEQ_CYC       = 3 * FRAME_CYC;
	localparam int RESET_CYC     = 10;
	localparam int N_SEQ         = 200;
	localparam int N_MIX         = 100;
	localparam int MIX_KEY_EVERY = 20;
	localparam int N_BAD         = 4;
	localparam int N_LEVEL       = 8;
	// worst case length of every test added up, then a quarter on top
	localparam int TEST_CYC      = RESET_CYC + 20 + N_SEQ * SEQ_CYC
		+ N_MIX * 2 + (N_MIX / MIX_KEY_EVERY) * SEQ_CYC
		+ N_BAD * 4 * FRAME_CYC + N_LEVEL * (RESET_CYC + 262);
	localparam int LIMIT_CYC     = TEST_CYC + TEST_CYC / 4;

	logic           clk_sys;
	logic           arst_n;
	logic           ps2_clk;
	logic           ps2_data;
	pad_t           joy0;
	pad_t           joy1;
	logic           upright;
	logic           test_sw;
	logic           cocktail;
	audio_level_t   audio_level;
	player_inputs_t player;
	dir_t [1:0]     joystick;
	logic           frame_err;
	logic           audio;

	// model state, key index order is up, down, left, right, fire1, fire2,
	// start1, start2, coin left, coin centre, coin right, slam
	logic [11:0]    held_m;
	logic           up_a;
	logic           down_a;
	logic           left_a;
	logic           right_a;
	logic           fire1_a;
	logic           fire2_a;
	dir_t           dir_m;
	player_inputs_t exp_player;
	dir_t [1:0]     exp_joystick;
	logic [15:0]    exp_ones;
	logic [7:0]     exp_ferr;
	logic           cmp_io;
	logic           audio_cnt;
	logic           audio_chk;
	logic           test_end;
	logic           report;
	logic [2:0]     test_id;
	int             err_total;
	logic [31:0]    rng;
	int             cycle_cnt;

	always #5 clk_sys = ~clk_sys;

	arcade_io_top dut0 (
		.clk_sys_i     (clk_sys),
		.arst_n_i      (arst_n),
		.ps2_clk_i     (ps2_clk),
		.ps2_data_i    (ps2_data),
		.joy0_i        (joy0),
		.joy1_i        (joy1),
		.upright_i     (upright),
		.test_i        (test_sw),
		.cocktail_i    (cocktail),
		.audio_level_i (audio_level),
		.player_o      (player),
		.joystick_o    (joystick),
		.frame_err_o   (frame_err),
		.audio_o       (audio)
	);

	io_checker chk0 (
		.clk_i          (clk_sys),
		.player_i       (player),
		.joystick_i     (joystick),
		.frame_err_i    (frame_err),
		.audio_i        (audio),
		.exp_player_i   (exp_player),
		.exp_joystick_i (exp_joystick),
		.exp_ones_i     (exp_ones),
		.exp_ferr_i     (exp_ferr),
		.cmp_io_i       (cmp_io),
		.audio_cnt_i    (audio_cnt),
		.audio_chk_i    (audio_chk),
		.test_id_i      (test_id),
		.test_end_i     (test_end),
		.report_i       (report),
		.err_total_o    (err_total)
	);

	// ====================
	// reference model, a control is pressed when the keyboard or either pad presses it
	always_comb begin
		up_a    = held_m[0] | joy0.up | joy1.up;
		down_a  = held_m[1] | joy0.down | joy1.down;
		left_a  = held_m[2] | joy0.left | joy1.left;
		right_a = held_m[3] | joy0.right | joy1.right;
		fire1_a = held_m[4] | joy0.fire1 | joy1.fire1;
		fire2_a = held_m[5] | joy0.fire2 | joy1.fire2;
		// nibble order is right, left, down, up, all active low
		if (upright) begin
			// turned monitor, stick right reads as up, down as right and so on
			dir_m = ~{down_a, up_a, left_a, right_a};
		end else begin
			dir_m = ~{right_a, left_a, down_a, up_a};
		end
		exp_joystick = {dir_m, dir_m};
		exp_player   = ~{held_m[10], held_m[9], held_m[8], test_sw, cocktail,
			held_m[11], held_m[7], held_m[6], fire1_a, fire2_a};
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// scan code of each model key, the first four need the E0 prefix
	function automatic logic [7:0] key_code(input int k);
		case (k)
			0:       return `IO_SC_UP;
			1:       return `IO_SC_DOWN;
			2:       return `IO_SC_LEFT;
			3:       return `IO_SC_RIGHT;
			4:       return `IO_SC_SPACE;
			5:       return `IO_SC_LALT;
			6:       return `IO_SC_1;
			7:       return `IO_SC_2;
			8:       return `IO_SC_5;
			9:       return `IO_SC_6;
			10:      return `IO_SC_7;
			default: return `IO_SC_T;
		endcase
	endfunction

	// ====================
	// one device clocked frame, data changes while the PS/2 clock is high
	task automatic send_frame(input logic [7:0] data, input logic bad_parity, input logic check);
		logic [10:0] bits;
		int          i;
		int          c;
		// odd parity over data plus parity bit, flipped when a bad frame is wanted
		bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
		for (i = 0; i < `IO_PS2_FRAME_BITS; i++) begin
			@(negedge clk_sys);
			ps2_data = bits[i];
			repeat (HALF_BIT - 1) @(negedge clk_sys);
			ps2_clk = 1'b0;
			for (c = 1; c <= HALF_BIT; c++) begin
				@(negedge clk_sys);
				// the stop bit edge must have reached player_o six cycles later
				cmp_io = check && (i == `IO_PS2_FRAME_BITS - 1) && (c == 6);
			end
			ps2_clk = 1'b1;
		end
	endtask

	// prefixes first, and the model takes the final code just before it goes out
	task automatic send_seq(input logic [7:0] code, input logic ext, input logic brk,
		input int key);
		if (ext) begin
			send_frame(`IO_SC_EXT, 1'b0, 1'b1);
		end
		if (brk) begin
			send_frame(`IO_SC_BREAK, 1'b0, 1'b1);
		end
		if (key >= 0) begin
			held_m[key] = ~brk;
		end
		send_frame(code, 1'b0, 1'b1);
	endtask

	// mapped keys, arrow codes without E0, plain codes behind E0 and one unmapped key
	task automatic send_random_seq();
		int   sel;
		logic brk;
		rng = xorshift32(rng);
		sel = rng % 15;
		brk = rng[20];
		if (sel < 12) begin
			send_seq(key_code(sel), sel < 4, brk, sel);
		end else if (sel == 12) begin
			send_seq(key_code(rng[9:8]), 1'b0, brk, -1);
		end else if (sel == 13) begin
			send_seq(key_code(4 + rng[10:8]), 1'b1, brk, -1);
		end else begin
			send_seq(8'h1C, 1'b0, brk, -1);
		end
	endtask

	task automatic finish_test(input logic [2:0] id, input logic [7:0] ferr);
		@(negedge clk_sys);
		test_id  = id;
		exp_ferr = ferr;
		test_end = 1'b1;
		@(negedge clk_sys);
		test_end = 1'b0;
	endtask

	// ====================
	initial begin
		int k;
		int key;
		int lvl;
		clk_sys     = 1'b0;
		arst_n      = 1'b0;
		ps2_clk     = 1'b1;
		ps2_data    = 1'b1;
		joy0        = '0;
		joy1        = '0;
		upright     = 1'b0;
		test_sw     = 1'b0;
		cocktail    = 1'b0;
		audio_level = '0;
		held_m      = '0;
		exp_ones    = '0;
		exp_ferr    = '0;
		cmp_io      = 1'b0;
		audio_cnt   = 1'b0;
		audio_chk   = 1'b0;
		test_end    = 1'b0;
		report      = 1'b0;
		test_id     = '0;
		rng         = 32'd59;

		// outputs inactive while reset is held and straight after it, no frame errors
		repeat (RESET_CYC) begin
			@(negedge clk_sys);
			cmp_io = 1'b1;
		end
		arst_n = 1'b1;
		repeat (8) begin
			@(negedge clk_sys);
			cmp_io = 1'b1;
		end
		@(negedge clk_sys);
		cmp_io = 1'b0;
		finish_test(3'd1, 8'd0);

		repeat (N_SEQ) begin
			send_random_seq();
		end
		finish_test(3'd2, 8'd0);

		// new pads and switches each pass, checked one cycle after they land
		for (k = 0; k < N_MIX; k++) begin
			@(negedge clk_sys);
			cmp_io   = 1'b0;
			rng      = xorshift32(rng);
			joy0     = rng[7:0];
			joy1     = rng[15:8];
			upright  = rng[16];
			test_sw  = rng[17];
			cocktail = rng[18];
			@(negedge clk_sys);
			cmp_io = 1'b1;
			if (k % MIX_KEY_EVERY == MIX_KEY_EVERY - 1) begin
				@(negedge clk_sys);
				cmp_io = 1'b0;
				send_random_seq();
			end
		end
		@(negedge clk_sys);
		cmp_io = 1'b0;
		finish_test(3'd3, 8'd0);

		// a released plain key is sent once with bad parity, then cleanly
		for (k = 0; k < N_BAD; k++) begin
			rng = xorshift32(rng);
			key = 4 + rng[2:0];
			if (held_m[key]) begin
				send_seq(key_code(key), 1'b0, 1'b1, key);
			end
			send_frame(key_code(key), 1'b1, 1'b1);
			send_seq(key_code(key), 1'b0, 1'b0, key);
		end
		finish_test(3'd4, 8'(N_BAD));

		// both ends of the range first, then random levels, each after a fresh reset
		for (k = 0; k < N_LEVEL; k++) begin
			rng = xorshift32(rng);
			if (k == 0) begin
				lvl = 0;
			end else if (k == 1) begin
				lvl = 15;
			end else begin
				lvl = rng[3:0];
			end
			@(negedge clk_sys);
			arst_n      = 1'b0;
			audio_level = 4'(lvl);
			held_m      = '0;
			repeat (RESET_CYC) @(negedge clk_sys);
			arst_n = 1'b1;
			// the first sample after release is the reset value, so skip it
			@(negedge clk_sys);
			audio_cnt = 1'b1;
			exp_ones  = 16'(lvl * 17);
			repeat (256) @(negedge clk_sys);
			audio_cnt = 1'b0;
			audio_chk = 1'b1;
			@(negedge clk_sys);
			audio_chk = 1'b0;
		end
		finish_test(3'd5, 8'd0);

		@(negedge clk_sys);
		report = 1'b1;
		@(negedge clk_sys);
		report = 1'b0;
		if (err_total == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// cycle counter that stops a stuck run
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < LIMIT_CYC) begin
			@(posedge clk_sys);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles, the tests did not reach their end", cycle_cnt);
		$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire
